/* src/icache_pkg.sv */
package icache_pkg;

  // cache geometry
  localparam int offset_w   = 4;                 // log2 bytes per line
  localparam int index_w    = 4;                 // log2 sets
  localparam int tag_w      = 32 - index_w - offset_w;
  localparam int set_n      = 1 << index_w;
  localparam int line_words = (1 << offset_w) / 4;
  localparam int word_w     = offset_w - 2;

  // apb register offsets
  localparam logic [31:0] csr_ctrl       = 32'h0000_0000;
  localparam logic [31:0] csr_miss_count = 32'h0000_0004;
  localparam logic [31:0] csr_busy_count = 32'h0000_0008;

  // axi encodings
  localparam logic [1:0] axi_burst_wrap = 2'b10;
  localparam logic [2:0] axi_size_word  = 3'b010;

  // fetch address, flat or split into cache fields
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic [tag_w-1:0]   tag;
      logic [index_w-1:0] index;
      logic [word_w-1:0]  word;
      logic [1:0]         byte_off;
    } fields;
  } icache_addr_t;

endpackage

/* src/icache_array.sv */
module icache_array
  import icache_pkg::*;
(
  input  logic              clock,
  input  logic              reset,

  input  icache_addr_t      addr,
  input  logic              invalidate,

  input  logic              fill_we,
  input  logic              fill_last,
  input  logic [word_w-1:0] fill_word,
  input  logic [31:0]       fill_data,

  output logic              hit,
  output logic [31:0]       inst
);

  // one bit per set
  logic [set_n-1:0] line_valid;
  logic [tag_w-1:0] line_tag  [set_n];
  logic [31:0]      line_data [set_n][line_words];

  logic [index_w-1:0] index;
  logic [tag_w-1:0]   tag;
  logic [word_w-1:0]  word;
  logic               fill_done;

  assign index = addr.fields.index;
  assign tag   = addr.fields.tag;
  assign word  = addr.fields.word;

  // last beat of a refill lands this cycle
  assign fill_done = fill_we & fill_last;

  // zero-latency lookup
  assign hit  = line_valid[index] & (line_tag[index] == tag);
  assign inst = line_data[index][word];

  // a fill completing under a fence survives: the set below overrides the clear
  always_ff @(posedge clock) begin
    if (reset) begin
      line_valid <= '0;
    end else begin
      if (invalidate) begin
        line_valid <= '0;
      end
      if (fill_done) begin
        line_valid[index] <= 1'b1;
      end
    end
  end

  // fetch addr is held during the refill, so it names the line being filled
  always_ff @(posedge clock) begin
    if (fill_we) begin
      line_data[index][fill_word] <= fill_data;
    end
    if (fill_done) begin
      line_tag[index] <= tag;
    end
  end

endmodule

/* src/icache_refill.sv */
module icache_refill
  import icache_pkg::*;
(
  input  logic              clock,
  input  logic              reset,

  input  icache_addr_t      addr,
  input  logic              hit,

  // axi read address
  output logic              arvalid,
  input  logic              arready,
  output logic [31:0]       araddr,
  output logic [7:0]        arlen,
  output logic [2:0]        arsize,
  output logic [1:0]        arburst,

  // axi read data
  input  logic              rvalid,
  output logic              rready,
  input  logic [63:0]       rdata,
  input  logic              rlast,

  // array write port
  output logic              fill_we,
  output logic              fill_last,
  output logic [word_w-1:0] fill_word,
  output logic [31:0]       fill_data,

  output logic              refill_start,
  output logic              busy
);

  // one-hot: bit 0 idle, bit 1 request, bit 2 response
  logic [2:0] state;
  logic [2:0] state_next;
  logic       st_idle;
  logic       st_req;
  logic       st_resp;

  logic              ar_fire;
  logic              r_fire;
  logic [word_w-1:0] word_cnt;

  assign st_idle = state[0];
  assign st_req  = state[1];
  assign st_resp = state[2];

  assign ar_fire = arvalid & arready;
  assign r_fire  = rvalid & rready;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= 3'b001;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    if (st_idle) begin
      if (!hit) begin
        state_next = 3'b010;
      end
    end else if (st_req) begin
      if (arready) begin
        state_next = 3'b100;
      end
    end else if (st_resp) begin
      if (rvalid && rlast) begin
        state_next = 3'b001;
      end
    end else begin
      state_next = 3'b001; // not one-hot, recover to idle
    end
  end

  // critical word first, memory wraps inside the line
  assign arvalid = st_req;
  assign araddr  = {addr.fields.tag, addr.fields.index, addr.fields.word, 2'b00};
  assign arlen   = 8'(line_words - 1);
  assign arsize  = axi_size_word;
  assign arburst = axi_burst_wrap;
  assign rready  = st_resp;

  // word position of the next beat, wraps at the line end
  always_ff @(posedge clock) begin
    if (ar_fire) begin
      word_cnt <= addr.fields.word;
    end else if (r_fire) begin
      word_cnt <= word_cnt + 1'b1;
    end
  end

  assign fill_we   = r_fire;
  assign fill_last = r_fire & rlast;
  assign fill_word = word_cnt;
  assign fill_data = word_cnt[0] ? rdata[63:32] : rdata[31:0]; // lane by addr bit 2

  assign refill_start = ar_fire;
  assign busy         = ~st_idle;

endmodule

/* src/icache_csr.sv */
module icache_csr
  import icache_pkg::*;
(
  input  logic        clock,
  input  logic        reset,

  // apb slave
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [31:0] paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,

  // events from the refill unit
  input  logic        refill_start,
  input  logic        busy,

  output logic        flush_req
);

  logic setup_rd;
  logic access_wr;

  logic sel_ctrl;
  logic sel_miss;
  logic sel_busy;

  logic [31:0] miss_count;
  logic [31:0] busy_count;
  logic [31:0] rd_mux;

  assign sel_ctrl = (paddr == csr_ctrl);
  assign sel_miss = (paddr == csr_miss_count);
  assign sel_busy = (paddr == csr_busy_count);

  // read data is sampled in setup so it is ready in the access cycle
  assign setup_rd  = psel & ~penable & ~pwrite;
  assign access_wr = psel & penable & pwrite;

  // one-cycle pulse, array invalidates at the end of the access
  assign flush_req = access_wr & sel_ctrl & pwdata[0];

  // refills, clear wins over a same-cycle event
  always_ff @(posedge clock) begin
    if (reset) begin
      miss_count <= '0;
    end else if (access_wr && sel_miss) begin
      miss_count <= '0;
    end else if (refill_start) begin
      miss_count <= miss_count + 1'b1;
    end
  end

  // cycles spent refilling
  always_ff @(posedge clock) begin
    if (reset) begin
      busy_count <= '0;
    end else if (access_wr && sel_busy) begin
      busy_count <= '0;
    end else if (busy) begin
      busy_count <= busy_count + 1'b1;
    end
  end

  // ctrl and unmapped offsets read as zero
  always_comb begin
    rd_mux = '0;
    if (sel_miss) begin
      rd_mux = miss_count;
    end else if (sel_busy) begin
      rd_mux = busy_count;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      prdata <= '0;
    end else if (setup_rd) begin
      prdata <= rd_mux;
    end
  end

endmodule

/* src/icache_top.sv */
module icache_top
  import icache_pkg::*;
(
  input  logic         clock,
  input  logic         reset,

  // fetch side
  input  logic         fencei,
  input  icache_addr_t addr,
  output logic         hit,
  output logic [31:0]  inst,

  // axi read
  output logic         arvalid,
  input  logic         arready,
  output logic [31:0]  araddr,
  output logic [7:0]   arlen,
  output logic [2:0]   arsize,
  output logic [1:0]   arburst,
  input  logic         rvalid,
  output logic         rready,
  input  logic [63:0]  rdata,
  input  logic         rlast,

  // apb
  input  logic         psel,
  input  logic         penable,
  input  logic         pwrite,
  input  logic [31:0]  paddr,
  input  logic [31:0]  pwdata,
  output logic [31:0]  prdata
);

  logic              fill_we;
  logic              fill_last;
  logic [word_w-1:0] fill_word;
  logic [31:0]       fill_data;
  logic              refill_start;
  logic              busy;
  logic              flush_req;

  icache_array u_array (
    .clock      (clock),
    .reset      (reset),
    .addr       (addr),
    .invalidate (fencei | flush_req), // either flush source clears all lines
    .fill_we    (fill_we),
    .fill_last  (fill_last),
    .fill_word  (fill_word),
    .fill_data  (fill_data),
    .hit        (hit),
    .inst       (inst)
  );

  icache_refill u_refill (
    .clock        (clock),
    .reset        (reset),
    .addr         (addr),
    .hit          (hit),
    .arvalid      (arvalid),
    .arready      (arready),
    .araddr       (araddr),
    .arlen        (arlen),
    .arsize       (arsize),
    .arburst      (arburst),
    .rvalid       (rvalid),
    .rready       (rready),
    .rdata        (rdata),
    .rlast        (rlast),
    .fill_we      (fill_we),
    .fill_last    (fill_last),
    .fill_word    (fill_word),
    .fill_data    (fill_data),
    .refill_start (refill_start),
    .busy         (busy)
  );

  icache_csr u_csr (
    .clock        (clock),
    .reset        (reset),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .paddr        (paddr),
    .pwdata       (pwdata),
    .prdata       (prdata),
    .refill_start (refill_start),
    .busy         (busy),
    .flush_req    (flush_req)
  );

endmodule

/* dv/axi_mem_model.sv */
module axi_mem_model
  import icache_pkg::*;
(
  input  logic        clock,
  input  logic        reset,

  // stall bits from the testbench lfsr
  input  logic        ar_stall,
  input  logic        r_stall,

  input  logic        arvalid,
  output logic        arready,
  input  logic [31:0] araddr,
  input  logic [7:0]  arlen,

  output logic        rvalid,
  input  logic        rready,
  output logic [63:0] rdata,
  output logic        rlast,

  // lookup into the memory image
  output logic [31:0] word_addr,
  input  logic [31:0] word_data
);

  timeunit 1ns;
  timeprecision 100ps;

  logic        active;
  logic [31:0] beat_addr;
  logic [7:0]  beats_left;

  assign arready   = ~active & ~ar_stall;
  assign rvalid    = active & ~r_stall;
  assign rlast     = (beats_left == 8'd0);
  assign word_addr = beat_addr;

  // unused lane carries the inverted word so a lane mixup shows
  assign rdata = beat_addr[2] ? {word_data, ~word_data} : {~word_data, word_data};

  always_ff @(posedge clock) begin
    if (reset) begin
      active     <= 1'b0;
      beat_addr  <= '0;
      beats_left <= '0;
    end else if (!active) begin
      if (arvalid && arready) begin
        active     <= 1'b1;
        beat_addr  <= araddr;
        beats_left <= arlen;
      end
    end else if (rvalid && rready) begin
      // step the word, stay inside the line
      beat_addr[offset_w-1:2] <= beat_addr[offset_w-1:2] + word_w'(1);
      beats_left              <= beats_left - 8'd1;
      if (beats_left == 8'd0) begin
        active <= 1'b0;
      end
    end
  end

endmodule

/* dv/icache_tb.sv */
module icache_tb
  import icache_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [31:0] line_a = 32'h0001_2340; // index 4
  localparam logic [31:0] line_b = 32'h0005_6740; // index 4 with another tag
  localparam logic [31:0] line_c = 32'h0000_0a80; // index 8

  logic         clock;
  logic         reset;
  logic         fencei;
  icache_addr_t addr;
  logic         hit;
  logic [31:0]  inst;
  logic         arvalid, arready, rvalid, rready, rlast;
  logic [31:0]  araddr;
  logic [7:0]   arlen;
  logic [2:0]   arsize;
  logic [1:0]   arburst;
  logic [63:0]  rdata;
  logic         psel, penable, pwrite;
  logic [31:0]  paddr, pwdata, prdata;
  logic         ar_stall, r_stall;
  logic [31:0]  word_addr, word_data;

  logic             exp_valid [set_n];  // expected line state
  logic [tag_w-1:0] exp_tag   [set_n];
  int               ar_count;
  int               busy_cycles;
  int               beat_n;
  logic             refilling;
  logic [31:0]      addr_lfsr  = 32'h3b03;
  logic [31:0]      stall_lfsr = 32'h3b03;
  logic [31:0]      stall_bits;
  logic [23:0]      tag_pool [4] = '{24'h000123, 24'h000567, 24'h00ab00, 24'h0f0001};

  icache_top uut (.*);

  axi_mem_model mem (
    .clock, .reset, .ar_stall, .r_stall, .arvalid, .arready, .araddr, .arlen,
    .rvalid, .rready, .rdata, .rlast, .word_addr, .word_data
  );

  // memory content is a fixed mix of the word address
  function automatic logic [31:0] mem_word(input logic [31:0] a);
    logic [31:0] w;
    w = {a[31:2], 2'b00};
    return (w * 32'h9e37_79b1) ^ {w[15:0], w[31:16]} ^ 32'h5a5a_0f0f;
  endfunction

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32 22 2 1
  endfunction

  task automatic take_bits(input int n, inout logic [31:0] state, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      state = lfsr_next(state);
      v     = {v[30:0], state[0]};
    end
  endtask

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1);
  endtask

  assign word_data = mem_word(word_addr);

  initial clock = 1'b0;
  always #4 clock = ~clock;

  always @(posedge clock) begin
    take_bits(1, stall_lfsr, stall_bits);
    ar_stall <= stall_bits[0];
    take_bits(1, stall_lfsr, stall_bits);
    r_stall  <= stall_bits[0];
  end

  // bus monitor sampled mid-cycle
  always @(negedge clock) begin
    if (!reset) begin
      if (hit) begin
        assert (inst == mem_word(addr.raw))
          else abort_run($sformatf("FAILED inst: got %h expected %h", inst, mem_word(addr.raw)));
      end
      // from arvalid rising through the rlast beat
      if (arvalid || refilling) begin
        busy_cycles++;
      end
      if (arvalid && arready) begin
        ar_count++;
        beat_n    = 0;
        refilling = 1'b1;
        assert (araddr == {addr.raw[31:2], 2'b00})
          else abort_run($sformatf("FAILED araddr: got %h expected %h", araddr,
                                   {addr.raw[31:2], 2'b00}));
        assert (arlen == 8'd3)
          else abort_run($sformatf("FAILED arlen: got %h expected 03", arlen));
        assert (arsize == 3'b010)
          else abort_run($sformatf("FAILED arsize: got %h expected 2", arsize));
        assert (arburst == 2'b10)
          else abort_run($sformatf("FAILED arburst: got %h expected 2", arburst));
      end
      if (rvalid && rready) begin
        beat_n++;
        assert (rlast == (beat_n == 4))
          else abort_run($sformatf("FAILED rlast: got %h expected %h", rlast, beat_n == 4));
        if (rlast) begin
          refilling = 1'b0;
        end
      end
    end
  end

  task automatic mark_line(input icache_addr_t a);
    exp_valid[a.fields.index] = 1'b1;
    exp_tag[a.fields.index]   = a.fields.tag;
  endtask

  task automatic wait_hit(input logic [31:0] a);
    int cycles;
    cycles = 0;
    while (!hit && cycles < 200) begin
      @(negedge clock);
      cycles++;
    end
    if (!hit) begin
      abort_run($sformatf("hit never came after a miss on address %h", a));
    end
  endtask

  task automatic fetch(input logic [31:0] a);
    icache_addr_t fa;
    logic         expect_hit;
    fa.raw     = a;
    expect_hit = exp_valid[fa.fields.index] && (exp_tag[fa.fields.index] == fa.fields.tag);
    @(posedge clock);
    addr <= fa;
    @(negedge clock);
    assert (hit == expect_hit)
      else abort_run($sformatf("FAILED hit: got %h expected %h at %h", hit, expect_hit, a));
    wait_hit(a);
    if (expect_hit) begin
      @(negedge clock); // give a stray request a cycle to show
      assert (!arvalid) else abort_run("a fetch that hit started a refill");
    end
    mark_line(fa);
  endtask

  // held address refills on its own once every line is gone
  task automatic after_flush();
    for (int i = 0; i < set_n; i++) begin
      exp_valid[i] = 1'b0;
    end
    @(negedge clock);
    assert (!hit) else abort_run($sformatf("FAILED hit: got %h expected 0 after flush", hit));
    wait_hit(addr.raw);
    mark_line(addr);
  endtask

  task automatic apb_write(input logic [31:0] a, input logic [31:0] d);
    @(posedge clock);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= a;
    pwdata  <= d;
    @(posedge clock);
    penable <= 1'b1;
    @(posedge clock);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic check_reg(input logic [31:0] a, input logic [31:0] expected, input string name);
    logic [31:0] got;
    @(posedge clock);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= a;
    @(posedge clock);
    penable <= 1'b1;
    @(negedge clock);
    got = prdata;
    @(posedge clock);
    psel    <= 1'b0;
    penable <= 1'b0;
    assert (got == expected)
      else abort_run($sformatf("FAILED %s: got %h expected %h", name, got, expected));
  endtask

  initial begin
    logic [31:0] v;
    logic [31:0] a;
    reset    = 1'b1;
    fencei   = 1'b0;
    addr.raw = line_a;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    paddr    = '0;
    pwdata   = '0;
    ar_count    = 0;
    busy_cycles = 0;
    beat_n      = 0;
    refilling   = 1'b0;
    for (int i = 0; i < set_n; i++) begin
      exp_valid[i] = 1'b0;
      exp_tag[i]   = '0;
    end
    repeat (16) @(posedge clock);
    reset <= 1'b0;

    fetch(line_a);
    fetch(line_a + 32'd4);
    fetch(line_a + 32'd8);
    fetch(line_a + 32'd12);
    fetch(line_b + 32'd8); // evicts line a
    fetch(line_a + 32'd4);
    fetch(line_c);

    @(posedge clock);
    fencei <= 1'b1;
    @(posedge clock);
    fencei <= 1'b0;
    after_flush();
    fetch(line_c + 32'd4);
    fetch(line_b);

    apb_write(csr_ctrl, 32'h1);
    after_flush();
    fetch(line_c);
    check_reg(csr_ctrl, 32'h0, "ctrl");
    check_reg(csr_miss_count, ar_count, "miss_count");
    check_reg(csr_busy_count, busy_cycles, "busy_count");

    // conflicting lines in two sets
    for (int i = 0; i < 60; i++) begin
      take_bits(5, addr_lfsr, v);
      a = {tag_pool[v[4:3]], v[2] ? 4'h4 : 4'hb, v[1:0], 2'b00};
      fetch(a);
    end
    check_reg(csr_miss_count, ar_count, "miss_count");
    check_reg(csr_busy_count, busy_cycles, "busy_count");

    apb_write(csr_miss_count, 32'h1234);
    apb_write(csr_busy_count, 32'hffff_ffff);
    ar_count    = 0;
    busy_cycles = 0;
    check_reg(csr_miss_count, ar_count, "miss_count");
    check_reg(csr_busy_count, busy_cycles, "busy_count");

    $display("Finished with no errors");
    $finish;
  end

endmodule

/* sim.f */
src/icache_pkg.sv
src/icache_array.sv
src/icache_refill.sv
src/icache_csr.sv
src/icache_top.sv
dv/axi_mem_model.sv
dv/icache_tb.sv

/* Makefile */
SIM      = verilator
TOP      = icache_tb
FILELIST = sim.f
FLAGS    = --binary --timing --assert --timescale 1ns/100ps -Wno-fatal
OBJ_DIR  = obj_dir

SOURCES  = $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
